// ==== logic/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // fetch data and byte addresses
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // lookup / miss sequencing in the cache core
    typedef enum logic [2:0] {
        LOOKUP,       // stage 2 compare, hits stream out
        MISS_REQ,     // line request waiting for rdy
        REFILL,       // words landing in the victim way
        REFILL_DONE,  // re-read of the refilled set
        UNC_REQ,
        UNC_WAIT,
        UNC_DONE      // uncached word on rdata
    } core_state_t;

    // bus master states
    typedef enum logic [1:0] {
        IDLE,
        BUS_READ,   // cyc/stb high, beats in flight
        BUS_LAST    // done pulse, bus released
    } wb_state_t;

    // default geometry, 4-way 16 sets x 4 words
    localparam int DEF_WAYS       = 4;
    localparam int DEF_SETS       = 16;
    localparam int DEF_LINE_WORDS = 4;

endpackage

`default_nettype wire

// ==== logic/refill_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// cache core <-> bus master, one outstanding request at a time
interface refill_if import icache_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input wire clk
);
    localparam int IDX_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    logic             req;         // held until rdy
    logic             uncached;    // single word, no allocate
    addr_t            addr;
    logic             rdy;
    logic             word_valid;
    word_t            word;
    logic [IDX_W-1:0] word_idx;    // position in the line
    logic             done;        // after the last word

    modport core (output req, uncached, addr, input rdy, word_valid, word, word_idx, done);
    modport bus  (input req, uncached, addr, output rdy, word_valid, word, word_idx, done);

    // request must not move while it waits for the master
    a_addr_stable: assert property (@(posedge clk)
        (req && !rdy) |=> (req && $stable(addr)));

endinterface

`default_nettype wire

// ==== logic/plru_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module plru_tree import icache_pkg::*; #(
    parameter int WAYS = DEF_WAYS,
    parameter int SETS = DEF_SETS
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [WAYS-1:0]           touch,      // one-hot way
    input  wire                      touch_en,
    input  wire [$clog2(SETS)-1:0]   touch_set,
    input  wire [$clog2(SETS)-1:0]   query_set,
    output logic [$clog2(WAYS)-1:0]  victim
);
    localparam int WAY_W = $clog2(WAYS);

    // heap order, node 1 is the root, bit 0 means go left
    logic [WAYS-1:1]  tree_q [SETS];
    logic [WAYS-1:1]  tree_nxt;
    logic [WAY_W-1:0] touch_way;

    always_comb begin
        touch_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (touch[w]) touch_way = WAY_W'(w);
        end
    end

    // path bits point away from the touched way
    always_comb begin
        int node;
        node     = 1;
        tree_nxt = tree_q[touch_set];
        for (int l = WAY_W - 1; l >= 0; l--) begin
            tree_nxt[node] = ~touch_way[l];
            node = 2 * node + int'(touch_way[l]);
        end
    end

    // walk from the root, msb of the way first
    always_comb begin
        int              node;
        logic [WAYS-1:1] bits;
        node   = 1;
        bits   = tree_q[query_set];
        victim = '0;
        for (int l = WAY_W - 1; l >= 0; l--) begin
            victim[l] = bits[node];
            node = 2 * node + int'(bits[node]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_en) begin
            tree_q[touch_set] <= tree_nxt;
        end
    end

    a_touch_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        touch_en |-> $onehot(touch));

endmodule

`default_nettype wire

// ==== logic/icache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_core import icache_pkg::*; #(
    parameter int WAYS       = DEF_WAYS,
    parameter int SETS       = DEF_SETS,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cpu_valid,
    input  wire addr_t               cpu_addr,
    input  wire                      cpu_uncached,
    input  wire                      cpu_stall,
    output logic                     busy,
    output word_t                    rdata,
    refill_if.core                   rf,
    output logic [WAYS-1:0]          plru_touch,
    output logic                     plru_touch_en,
    output logic [$clog2(SETS)-1:0]  plru_touch_set,
    output logic [$clog2(SETS)-1:0]  plru_query_set,
    input  wire [$clog2(WAYS)-1:0]   plru_victim
);
    localparam int WAY_W  = $clog2(WAYS);
    localparam int IDX_W  = $clog2(SETS);
    localparam int OFF_W  = $clog2(LINE_WORDS * 4);
    localparam int WOFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W  = 32 - IDX_W - OFF_W;

    core_state_t state, state_nxt;

    // request register
    logic              req_valid;
    logic              req_unc;
    addr_t             req_addr;
    logic [TAG_W-1:0]  req_tag;
    logic [IDX_W-1:0]  req_idx;
    logic [WOFF_W-1:0] req_woff;

    // storage
    logic [TAG_W-1:0]          tag_mem  [WAYS][SETS];
    logic [SETS-1:0]           valid_q  [WAYS];
    word_t [LINE_WORDS-1:0]    data_mem [WAYS][SETS];

    // stage 2 copies of the indexed set
    logic [TAG_W-1:0]          tag_rd_q  [WAYS];
    logic [WAYS-1:0]           vld_rd_q;
    word_t [LINE_WORDS-1:0]    line_rd_q [WAYS];

    logic [IDX_W-1:0] rd_idx;
    logic             rd_en;
    logic             accept;
    logic [WAYS-1:0]  hit;
    word_t            hit_word;
    word_t            unc_word;
    logic [WAY_W-1:0] victim_sel;
    logic [WAY_W-1:0] victim_q;

    assign req_tag  = req_addr[31 -: TAG_W];
    assign req_idx  = req_addr[OFF_W +: IDX_W];
    assign req_woff = req_addr[2 +: WOFF_W];

    // new request only when the current one is finished
    assign accept = !cpu_stall && !busy && (state == LOOKUP || state == UNC_DONE);

    // refill states keep reading the missed set
    assign rd_idx = (state == REFILL || state == REFILL_DONE) ? req_idx
                                                              : cpu_addr[OFF_W +: IDX_W];
    assign rd_en  = accept || (state == REFILL_DONE);

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = vld_rd_q[w] && (tag_rd_q[w] == req_tag);
            if (hit[w]) hit_word = hit_word | line_rd_q[w][req_woff];
        end
    end

    // lowest invalid way first, else the tree
    always_comb begin
        victim_sel = plru_victim;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!vld_rd_q[w]) victim_sel = WAY_W'(w);
        end
    end

    assign busy  = req_valid && (req_unc ? (state != UNC_DONE) : !(|hit));
    assign rdata = (state == UNC_DONE) ? unc_word : hit_word;

    assign rf.req      = (state == MISS_REQ) || (state == UNC_REQ);
    assign rf.uncached = (state == UNC_REQ);
    assign rf.addr     = (state == UNC_REQ) ? {req_addr[31:2], 2'b00}
                                            : {req_addr[31:OFF_W], {OFF_W{1'b0}}};

    assign plru_touch_en  = (state == REFILL && rf.done) ||
                            (state == LOOKUP && req_valid && !req_unc && (|hit));
    assign plru_touch     = (state == REFILL) ? (WAYS'(1) << victim_q) : hit;
    assign plru_touch_set = req_idx;
    assign plru_query_set = req_idx;

    always_comb begin
        state_nxt = state;
        case (state)
            LOOKUP: begin
                if (req_valid && req_unc) begin
                    state_nxt = UNC_REQ;
                end else if (req_valid && !(|hit)) begin
                    state_nxt = MISS_REQ;
                end
            end
            MISS_REQ:    if (rf.rdy) state_nxt = REFILL;
            REFILL:      if (rf.done) state_nxt = REFILL_DONE;
            REFILL_DONE: state_nxt = LOOKUP;
            UNC_REQ:     if (rf.rdy) state_nxt = UNC_WAIT;
            UNC_WAIT:    if (rf.done) state_nxt = UNC_DONE;
            UNC_DONE:    if (!cpu_stall) state_nxt = LOOKUP;  // hold word for the cpu
            default:     state_nxt = LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= LOOKUP;
            req_valid <= 1'b0;
            req_unc   <= 1'b0;
            vld_rd_q  <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                req_valid <= cpu_valid;
                req_unc   <= cpu_uncached;
            end
            if (rd_en) begin
                for (int w = 0; w < WAYS; w++) begin
                    vld_rd_q[w] <= valid_q[w][rd_idx];
                end
            end
        end
    end

    // line becomes valid once all words are in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (state == REFILL && rf.done) begin
            valid_q[victim_q][req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_addr <= cpu_addr;
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                tag_rd_q[w]  <= tag_mem[w][rd_idx];
                line_rd_q[w] <= data_mem[w][rd_idx];
            end
        end
        if (state == MISS_REQ && rf.rdy) victim_q <= victim_sel;
        if (state == UNC_WAIT && rf.word_valid) unc_word <= rf.word;
        if (state == REFILL && rf.word_valid) begin
            data_mem[victim_q][req_idx][rf.word_idx] <= rf.word;  // one word per beat
        end
        if (state == REFILL && rf.done) tag_mem[victim_q][req_idx] <= req_tag;
    end

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hit));

    // miss and uncached sequences run on a held request and keep the cpu waiting
    a_seq_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state != LOOKUP) |-> (req_valid && (busy || state == UNC_DONE)));

endmodule

`default_nettype wire

// ==== logic/wb_refill_master.sv ====
`timescale 1ns/1ps
`default_nettype none

// wishbone classic reads, whole line or a single word
module wb_refill_master import icache_pkg::*; #(
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  wire         clk,
    input  wire         rst_n,
    refill_if.bus       rf,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output addr_t       wb_adr,
    input  wire word_t  wb_dat_i,
    input  wire         wb_ack
);
    localparam int IDX_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    wb_state_t        state;
    logic [IDX_W-1:0] beat_q;   // beat in flight
    logic [IDX_W-1:0] last_q;   // index of the final beat
    logic             beat_ack;
    logic             start;

    assign start    = (state == IDLE) && rf.req;
    assign beat_ack = wb_stb && wb_ack;
    assign wb_we    = 1'b0;  // read-only

    assign rf.rdy        = (state == IDLE);
    assign rf.word_valid = beat_ack;
    assign rf.word       = wb_dat_i;
    assign rf.word_idx   = beat_q;
    assign rf.done       = (state == BUS_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            beat_q <= '0;
            last_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state  <= BUS_READ;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        beat_q <= '0;
                        last_q <= rf.uncached ? '0 : IDX_W'(LINE_WORDS - 1);
                    end
                end
                BUS_READ: begin
                    if (beat_ack) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == last_q) begin
                            state  <= BUS_LAST;
                            wb_cyc <= 1'b0;   // released the cycle after the last ack
                            wb_stb <= 1'b0;
                        end
                    end
                end
                BUS_LAST: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // stb stays up, address steps a word per ack
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr <= rf.addr;
        end else if (beat_ack) begin
            wb_adr <= wb_adr + 32'd4;
        end
    end

    // a beat keeps cyc, stb and its address until the ack
    a_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

// ==== logic/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int WAYS       = DEF_WAYS,
    parameter int SETS       = DEF_SETS,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  wire         clk,
    input  wire         rst_n,
    // fetch side
    input  wire         cpu_valid,
    input  wire addr_t  cpu_addr,
    input  wire         cpu_uncached,
    input  wire         cpu_stall,
    output logic        busy,
    output word_t       rdata,
    // wishbone master
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output addr_t       wb_adr,
    input  wire word_t  wb_dat_i,
    input  wire         wb_ack
);
    logic [WAYS-1:0]         plru_touch;
    logic                    plru_touch_en;
    logic [$clog2(SETS)-1:0] plru_touch_set;
    logic [$clog2(SETS)-1:0] plru_query_set;
    logic [$clog2(WAYS)-1:0] plru_victim;

    refill_if #(.LINE_WORDS(LINE_WORDS)) rf_bus (.clk(clk));

    icache_core #(
        .WAYS       (WAYS),
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) u_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_valid      (cpu_valid),
        .cpu_addr       (cpu_addr),
        .cpu_uncached   (cpu_uncached),
        .cpu_stall      (cpu_stall),
        .busy           (busy),
        .rdata          (rdata),
        .rf             (rf_bus.core),
        .plru_touch     (plru_touch),
        .plru_touch_en  (plru_touch_en),
        .plru_touch_set (plru_touch_set),
        .plru_query_set (plru_query_set),
        .plru_victim    (plru_victim)
    );

    plru_tree #(
        .WAYS (WAYS),
        .SETS (SETS)
    ) u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .touch     (plru_touch),
        .touch_en  (plru_touch_en),
        .touch_set (plru_touch_set),
        .query_set (plru_query_set),
        .victim    (plru_victim)
    );

    wb_refill_master #(
        .LINE_WORDS (LINE_WORDS)
    ) u_wbm (
        .clk      (clk),
        .rst_n    (rst_n),
        .rf       (rf_bus.bus),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/wb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// wishbone classic read slave, word at a is a ^ 0x5A5A0000
module wb_mem_model import icache_pkg::*; #(
    parameter logic [7:0] SEED = 8'd72
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire addr_t  wb_adr,
    output word_t       wb_dat,
    output logic        wb_ack,
    output int          beat_count
);
    logic [7:0] lfsr;
    logic [1:0] wait_left;
    logic       active;     // a beat is under way

    // fibonacci, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // outputs change on the falling edge only
    always @(negedge clk or negedge rst_n) begin
        logic [1:0] delay;
        if (!rst_n) begin
            lfsr      = SEED;
            wb_ack    <= 1'b0;
            wb_dat    <= '0;
            wait_left <= '0;
            active    <= 1'b0;
        end else if (!(wb_cyc && wb_stb && !wb_we)) begin
            wb_ack <= 1'b0;
            active <= 1'b0;
        end else begin
            wb_dat <= {wb_adr[31:2], 2'b00} ^ 32'h5A5A_0000;
            if (!active || wb_ack) begin
                // new beat, one lfsr step per delay bit
                lfsr      = lfsr_step(lfsr);
                delay[1]  = lfsr[0];
                lfsr      = lfsr_step(lfsr);
                delay[0]  = lfsr[0];
                active    <= 1'b1;
                wait_left <= delay;
                wb_ack    <= (delay == 2'd0);
            end else begin
                wait_left <= wait_left - 1'b1;
                wb_ack    <= (wait_left == 2'd1);
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) beat_count <= 0;
        else if (wb_cyc && wb_stb && wb_ack) beat_count <= beat_count + 1;  // completed beat
    end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();
    localparam int LINE_WORDS  = DEF_LINE_WORDS;
    localparam int NUM_FETCHES = 27;
    localparam int MAX_WAIT    = LINE_WORDS * 5 + 10;
    localparam int TIMEOUT_CYC = NUM_FETCHES * MAX_WAIT + 200;

    logic  clk, rst_n;
    logic  cpu_valid, cpu_uncached, cpu_stall, busy;
    addr_t cpu_addr, wb_adr;
    word_t rdata, wb_dat_i;
    logic  wb_cyc, wb_stb, wb_we, wb_ack;
    int    beats;
    int    errors = 0;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) clk_gen (.clk(clk), .rst_n(rst_n));

    icache_top #(.LINE_WORDS(LINE_WORDS)) UUT (.*);

    wb_mem_model #(.SEED(8'd72)) mem (
        .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat(wb_dat_i), .wb_ack(wb_ack), .beat_count(beats)
    );

    function automatic word_t expected_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(string name, int got, int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic compare_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // called on a falling edge, lat is cycles until busy low
    task automatic fetch(addr_t a, logic unc, output int lat);
        cpu_valid    = 1'b1;
        cpu_addr     = a;
        cpu_uncached = unc;
        @(negedge clk);
        lat = 1;
        while (busy && lat < MAX_WAIT) begin
            @(negedge clk);
            lat++;
        end
        if (busy) begin
            errors++;
            $display("fetch of %h still busy after %0d cycles", a, lat);
        end
        compare_word($sformatf("rdata @%h", a), rdata, expected_word(a));
        cpu_valid = 1'b0;
    endtask

    task automatic expect_fetch(addr_t a, logic unc, int exp_beats, logic exp_hit);
        int b0;
        int lat;
        b0 = beats;
        fetch(a, unc, lat);
        compare_count($sformatf("beats @%h", a), beats - b0, exp_beats);
        if (exp_hit) compare_count($sformatf("hit latency @%h", a), lat, 1);
    endtask

    task automatic cold_miss_then_stream();
        expect_fetch(32'h0000_1000, 1'b0, LINE_WORDS, 1'b0);
        for (int i = 1; i < LINE_WORDS; i++) begin
            expect_fetch(32'h0000_1000 + addr_t'(4 * i), 1'b0, 0, 1'b1);  // one per cycle
        end
    endtask

    task automatic uncached_bypass();
        expect_fetch(32'h0000_2008, 1'b1, 1, 1'b0);
        expect_fetch(32'h0000_2008, 1'b1, 1, 1'b0);
        expect_fetch(32'h0000_2008, 1'b0, LINE_WORDS, 1'b0);  // still not allocated
    endtask

    // five tags in set 3, E evicts A
    task automatic plru_replacement();
        addr_t line [5];
        for (int i = 0; i < 5; i++) begin
            line[i] = 32'h0000_0030 + addr_t'((i + 1) << 16);
            expect_fetch(line[i], 1'b0, LINE_WORDS, 1'b0);
        end
        for (int i = 1; i < 5; i++) begin
            expect_fetch(line[i], 1'b0, 0, 1'b1);
        end
        expect_fetch(line[0], 1'b0, LINE_WORDS, 1'b0);
    endtask

    task automatic stall_hold();
        word_t held;
        int    b0;
        expect_fetch(32'h0000_1004, 1'b0, 0, 1'b1);
        held      = rdata;
        b0        = beats;
        cpu_stall = 1'b1;
        cpu_valid = 1'b1;
        cpu_addr  = 32'h0000_3000;  // a miss, held back
        repeat (6) begin
            @(negedge clk);
            compare_word("rdata under stall", rdata, held);
            compare_flag("busy under stall", busy, 1'b0);
        end
        compare_count("beats under stall", beats - b0, 0);
        cpu_stall = 1'b0;
        expect_fetch(32'h0000_3000, 1'b0, LINE_WORDS, 1'b0);
    endtask

    task automatic wait_state_sweep();
        addr_t a;
        for (int s = 0; s < 8; s++) begin
            a = 32'h0006_0000 + addr_t'(s * 16 + (s % LINE_WORDS) * 4);
            expect_fetch(a, 1'b0, LINE_WORDS, 1'b0);
        end
    endtask

    // the master only ever reads
    always @(negedge clk) begin
        if (rst_n && wb_cyc) compare_flag("wb_we", wb_we, 1'b0);
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("run timed out after %0d cycles", TIMEOUT_CYC);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        cpu_valid    = 1'b0;
        cpu_addr     = '0;
        cpu_uncached = 1'b0;
        cpu_stall    = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        compare_flag("busy after reset", busy, 1'b0);
        compare_flag("wb_cyc after reset", wb_cyc, 1'b0);
        compare_flag("wb_stb after reset", wb_stb, 1'b0);
        cold_miss_then_stream();
        uncached_bypass();
        plru_replacement();
        stall_hold();
        wait_state_sweep();
        $display("errors: %0d, bus beats: %0d", errors, beats);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
logic/icache_pkg.sv
logic/refill_if.sv
logic/plru_tree.sv
logic/icache_core.sv
logic/wb_refill_master.sv
logic/icache_top.sv
sim/tb_clock_gen.sv
sim/wb_mem_model.sv
sim/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f icache_top.f -o $(TOP)_sim
	out="$$(./obj_dir/$(TOP)_sim)"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
